// File: project.f
+incdir+design
design/gus_io_pkg.sv
design/io_bus_slave.sv
design/pwm_gen.sv
design/uart_tx.sv
design/uart_rx.sv
design/gus_io_top.sv
sim/gus_io_checker.sv
sim/gus_io_tb.sv

// File: sim/gus_io_tb.sv
// Table-driven testbench for the peripheral block.
// Inputs change 1 ns after the rising edge and outputs are read at that same point.
// TX frames are captured by a background monitor. A cycle limit ends a hung run.
`timescale 1ns/1ps
`include "gus_io_macros.svh"

module gus_io_tb;

	localparam int BIT_CYC    = `GUS_IO_UART_DIVIDER;
	localparam int PWM_PERIOD = (1 << `GUS_IO_PWM_BITS) - 1;  // 255 cycles
	localparam gus_io_pkg::gp_in_t   GP_IN_VAL = 7'h5a;
	localparam gus_io_pkg::io_word_t F_RXV  = 16'h1 << `GUS_IO_FLAG_RXVALID;
	localparam gus_io_pkg::io_word_t F_TXR  = 16'h1 << `GUS_IO_FLAG_TXRDY;
	localparam gus_io_pkg::io_word_t F_OVR  = 16'h1 << `GUS_IO_FLAG_OVERRUN;
	localparam gus_io_pkg::io_word_t F_FRM  = 16'h1 << `GUS_IO_FLAG_FRAME;
	localparam gus_io_pkg::io_word_t F_PWM  = 16'h1 << `GUS_IO_FLAG_PWM;
	localparam gus_io_pkg::io_word_t F_UART = F_RXV | F_TXR | F_OVR | F_FRM;

	typedef enum {K_WR, K_RD, K_SEND, K_TXCAP, K_PWM, K_IRQ, K_GPO} kind_t;

	typedef struct {
		kind_t                kind;
		int                   addr;  // Register, or 1 = background send / wait allowed
		gus_io_pkg::io_word_t data;  // Write data, read mask, byte or wait budget
		gus_io_pkg::io_word_t exp;   // Expected value, stop bit or {irq, vec}
	} entry_t;

	logic                   clk;
	logic                   reset;
	logic                   req;
	gus_io_pkg::io_req_t    bus_req;
	logic                   ack;
	gus_io_pkg::io_word_t   rdata;
	gus_io_pkg::gp_in_t     gp_in;
	logic                   rxd;
	logic                   txd;
	logic                   pwm_out;
	logic                   gpo;
	logic                   irq;
	gus_io_pkg::irq_vec_t   irq_vec;

	entry_t                 table_q[$];
	logic [9:0]             tx_frames[$];  // {stop, data, start}
	logic [15:0]            lfsr_state = 16'd98;
	logic                   send_busy = 1'b0;
	gus_io_pkg::uart_byte_t bg_byte;       // Byte for a background send
	logic                   bg_stop;
	int                     checks = 0;
	int                     errors = 0;
	int                     cycle_count = 0;
	int                     cycle_limit = 1000000;

	gus_io_top dut_i (
		.clk, .reset, .req, .bus(bus_req), .ack, .rdata, .gp_in,
		.rxd, .txd, .pwm_out, .gpo, .irq, .irq_vec
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 8 ns period
	end

	task automatic tick();
		@(posedge clk);
		#1;  // Drive and sample point
	endtask

	// ---------------------------------------------------------------------------
	// Compare tasks
	task automatic check_word(input string what, input gus_io_pkg::io_word_t got,
	                          input gus_io_pkg::io_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR @ %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_byte(input string what, input gus_io_pkg::uart_byte_t got,
	                          input gus_io_pkg::uart_byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR @ %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_vec(input string what, input gus_io_pkg::irq_vec_t got,
	                         input gus_io_pkg::irq_vec_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR @ %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR @ %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic gus_io_pkg::uart_byte_t lfsr_byte();
		gus_io_pkg::uart_byte_t b;
		b = '0;
		for (int i = 0; i < 8; i++)
			b = {b[6:0], lfsr_bit()};  // One step per bit
		return b;
	endfunction

	// ---------------------------------------------------------------------------
	// Host, serial and PWM drivers
	task automatic bus_access(input gus_io_pkg::io_addr_t addr, input logic we,
	                          input gus_io_pkg::io_word_t wdata,
	                          output gus_io_pkg::io_word_t data);
		bus_req.addr  = addr;
		bus_req.we    = we;
		bus_req.wdata = wdata;
		req = 1'b1;
		do
			tick();
		while (ack !== 1'b1);  // May stall on the UART
		data = rdata;
		req = 1'b0;
		do
			tick();
		while (ack !== 1'b0);
	endtask

	task automatic serial_send(input gus_io_pkg::uart_byte_t data, input logic stop);
		logic [9:0] frame;
		frame = {stop, data, 1'b0};  // Start bit goes out first
		while (send_busy)
			tick();
		send_busy = 1'b1;
		for (int i = 0; i < 10; i++) begin
			rxd = frame[i];
			repeat (BIT_CYC) tick();
		end
		rxd = 1'b1;  // Idle line
		send_busy = 1'b0;
	endtask

	// Skips two rising edges so the new duty is in effect, then counts one period
	task automatic measure_pwm(output int highs);
		int   rises;
		int   t;
		logic prev;
		rises = 0;
		t = 0;
		prev = pwm_out;
		while (rises < 2 && t < 4 * PWM_PERIOD) begin
			tick();
			t++;
			if (pwm_out && !prev)
				rises++;
			prev = pwm_out;
		end
		highs = 0;
		for (int k = 0; k < PWM_PERIOD; k++) begin
			if (pwm_out)
				highs++;
			tick();
		end
	endtask

	// Captures every frame on txd at mid-bit
	initial begin
		logic [9:0] frame;
		wait (reset === 1'b0);
		forever begin
			@(negedge txd);
			repeat (BIT_CYC / 2) @(posedge clk);
			#1;
			frame[0] = txd;
			for (int i = 1; i < 10; i++) begin
				repeat (BIT_CYC) tick();
				frame[i] = txd;
			end
			tx_frames.push_back(frame);
		end
	end

	// ---------------------------------------------------------------------------
	// Stimulus table
	function automatic void push_entry(input kind_t kind, input int addr,
	                                   input gus_io_pkg::io_word_t data,
	                                   input gus_io_pkg::io_word_t exp);
		entry_t e;
		e.kind = kind;
		e.addr = addr;
		e.data = data;
		e.exp  = exp;
		table_q.push_back(e);
	endfunction

	function automatic int entry_budget(input entry_t e);
		case (e.kind)
			K_SEND:  return 20 * BIT_CYC + 10;  // May queue behind a running frame
			K_PWM:   return 5 * PWM_PERIOD + 5;
			K_IRQ:   return int'(e.data) + 2;
			K_GPO:   return 1;
			default: return 12 * BIT_CYC;  // Bus access or TX frame
		endcase
	endfunction

	task automatic build_table(input gus_io_pkg::uart_byte_t b0, input gus_io_pkg::uart_byte_t b1);
		push_entry(K_RD, `GUS_IO_ADDR_IRQEN, 16'hffff, 16'h0000);  // Reset values
		push_entry(K_RD, `GUS_IO_ADDR_PWM_FLAGS, ~F_PWM, F_TXR);
		push_entry(K_RD, 3, 16'hffff, 16'h0000);
		push_entry(K_RD, 5, 16'hffff, 16'h0000);
		push_entry(K_RD, 7, 16'hffff, 16'h0000);
		push_entry(K_WR, `GUS_IO_ADDR_IRQEN, 16'hfff4, 0);  // Only 4 bits kept
		push_entry(K_RD, `GUS_IO_ADDR_IRQEN, 16'hffff, 16'h0004);
		push_entry(K_WR, `GUS_IO_ADDR_IRQEN, 16'h0000, 0);
		push_entry(K_WR, `GUS_IO_ADDR_PORT, 16'h0001, 0);
		push_entry(K_GPO, 0, 0, 16'h0001);
		push_entry(K_RD, `GUS_IO_ADDR_PORT, 16'hffff, {8'h00, GP_IN_VAL, 1'b1});
		push_entry(K_WR, `GUS_IO_ADDR_PORT, 16'hfffe, 0);
		push_entry(K_GPO, 0, 0, 16'h0000);
		push_entry(K_RD, `GUS_IO_ADDR_PORT, 16'hffff, {8'h00, GP_IN_VAL, 1'b0});
		push_entry(K_WR, `GUS_IO_ADDR_UART, {8'h00, b0}, 0);  // TX back to back
		push_entry(K_RD, `GUS_IO_ADDR_PWM_FLAGS, F_TXR, 16'h0000);
		push_entry(K_WR, `GUS_IO_ADDR_UART, {8'h00, b1}, 0);
		push_entry(K_TXCAP, 0, 0, {8'h00, b0});
		push_entry(K_TXCAP, 1, 0, {8'h00, b1});
		push_entry(K_SEND, 0, 16'h00a5, 1);  // RX single byte
		push_entry(K_RD, `GUS_IO_ADDR_UART, 16'hffff, 16'h00a5);
		push_entry(K_RD, `GUS_IO_ADDR_PWM_FLAGS, F_UART, F_TXR);
		push_entry(K_SEND, 1, 16'h003c, 1);  // Read waits for this one
		push_entry(K_RD, `GUS_IO_ADDR_UART, 16'hffff, 16'h003c);
		push_entry(K_RD, `GUS_IO_ADDR_PWM_FLAGS, F_UART, F_TXR);
		push_entry(K_SEND, 0, 16'h0011, 1);  // Overrun
		push_entry(K_SEND, 0, 16'h0022, 1);
		push_entry(K_RD, `GUS_IO_ADDR_PWM_FLAGS, F_UART, F_RXV | F_TXR | F_OVR);
		push_entry(K_RD, `GUS_IO_ADDR_UART, 16'hffff, 16'h0022);
		push_entry(K_RD, `GUS_IO_ADDR_PWM_FLAGS, F_UART, F_TXR);
		push_entry(K_SEND, 0, 16'h005a, 0);  // Bad stop bit
		push_entry(K_RD, `GUS_IO_ADDR_PWM_FLAGS, F_UART, F_RXV | F_TXR | F_FRM);
		push_entry(K_RD, `GUS_IO_ADDR_UART, 16'hffff, 16'h005a);
		push_entry(K_WR, `GUS_IO_ADDR_PWM_FLAGS, 16'd0, 0);  // PWM duty sweep
		push_entry(K_PWM, 0, 0, 16'd0);
		push_entry(K_WR, `GUS_IO_ADDR_PWM_FLAGS, 16'd77, 0);
		push_entry(K_PWM, 0, 0, 16'd77);
		push_entry(K_WR, `GUS_IO_ADDR_PWM_FLAGS, 16'd255, 0);
		push_entry(K_PWM, 0, 0, 16'd255);
		push_entry(K_WR, `GUS_IO_ADDR_PWM_FLAGS, 16'd77, 0);  // Clears the period flag
		push_entry(K_WR, `GUS_IO_ADDR_IRQEN, 16'h0008, 0);
		push_entry(K_IRQ, 0, PWM_PERIOD + 5, 16'h0007);  // irq high, vector 3
		push_entry(K_WR, `GUS_IO_ADDR_PWM_FLAGS, 16'd77, 0);
		push_entry(K_IRQ, 0, 2, 16'h0000);  // irq low
		push_entry(K_WR, `GUS_IO_ADDR_IRQEN, 16'h0009, 0);
		push_entry(K_SEND, 0, 16'h0066, 1);
		push_entry(K_IRQ, 0, 2, 16'h0004);  // RX wins, vector 0
		push_entry(K_RD, `GUS_IO_ADDR_UART, 16'hffff, 16'h0066);
	endtask

	task automatic run_entry(input entry_t e);
		gus_io_pkg::io_word_t got;
		logic [9:0]           frame;
		int                   highs;
		int                   t;
		case (e.kind)
			K_WR: bus_access(gus_io_pkg::io_addr_t'(e.addr), 1'b1, e.data, got);
			K_RD: begin
				bus_access(gus_io_pkg::io_addr_t'(e.addr), 1'b0, '0, got);
				check_word($sformatf("read of address %0d", e.addr), got & e.data, e.exp);
			end
			K_SEND: begin
				if (e.addr != 0) begin
					bg_byte = e.data[7:0];
					bg_stop = e.exp[0];
					fork
						serial_send(bg_byte, bg_stop);
					join_none
				end else begin
					serial_send(e.data[7:0], e.exp[0]);
				end
			end
			K_TXCAP: begin
				if (e.addr == 0)
					check_bit("frame done before write ack", tx_frames.size() != 0, 1'b1);
				while (tx_frames.size() == 0)
					tick();
				frame = tx_frames.pop_front();
				check_bit("txd start bit", frame[0], 1'b0);
				check_byte("txd data", frame[8:1], e.exp[7:0]);
				check_bit("txd stop bit", frame[9], 1'b1);
			end
			K_PWM: begin
				measure_pwm(highs);
				check_word("pwm high cycles", gus_io_pkg::io_word_t'(highs), e.exp);
			end
			K_IRQ: begin
				t = 0;
				while (irq !== e.exp[2] && t < int'(e.data)) begin
					tick();
					t++;
				end
				check_bit("irq", irq, e.exp[2]);
				if (e.exp[2])
					check_vec("irq_vec", irq_vec, e.exp[1:0]);
			end
			K_GPO: check_bit("gpo", gpo, e.exp[0]);
		endcase
	endtask

	// ---------------------------------------------------------------------------
	initial begin
		while (cycle_count <= cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		gus_io_pkg::uart_byte_t tx_b0;
		gus_io_pkg::uart_byte_t tx_b1;
		int                     err_before;
		req     = 1'b0;
		bus_req = '0;
		gp_in   = GP_IN_VAL;
		rxd     = 1'b1;
		reset   = 1'b1;
		tx_b0 = lfsr_byte();
		tx_b1 = lfsr_byte();
		build_table(tx_b0, tx_b1);
		cycle_limit = 4 + 200;  // Reset plus margin
		foreach (table_q[i])
			cycle_limit += entry_budget(table_q[i]);
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		err_before = errors;
		check_bit("ack after reset", ack, 1'b0);
		check_bit("irq after reset", irq, 1'b0);
		check_bit("pwm_out after reset", pwm_out, 1'b0);
		check_bit("gpo after reset", gpo, 1'b0);
		check_bit("txd after reset", txd, 1'b1);
		$display("reset state: %s", errors == err_before ? "ok" : "fail");
		foreach (table_q[i]) begin
			err_before = errors;
			run_entry(table_q[i]);
			$display("step %0d %s: %s", i, table_q[i].kind.name(),
			         errors == err_before ? "ok" : "fail");
		end
		errors += dut_i.u_slave.chk_i.assert_fails;  // Bound assertion failures
		$display("%0d steps, %0d checks, %0d errors", table_q.size() + 1, checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: sim/gus_io_checker.sv
// Concurrent checks on the bus slave, attached to every io_bus_slave by bind.
// Assumes the host holds req until it sees ack and drops it before the next access.
`timescale 1ns/1ps

module gus_io_checker (
	input logic                 clk,
	input logic                 reset,
	input logic                 req,
	input logic                 ack,
	input logic                 irq,
	input gus_io_pkg::irq_vec_t irq_vec,
	input gus_io_pkg::irq_en_t  irq_en
);

	int assert_fails = 0;  // Failed assertions so far

	// ---------------------------------------------------------------------------
	// Handshake
	ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> $past(req))  // Access was requested
		else begin
			assert_fails++;
			$error("ack rose with no req pending");
		end

	ack_holds: assert property (@(posedge clk) disable iff (reset)
		(ack && req) |=> ack)  // Released only after req drops
		else begin
			assert_fails++;
			$error("ack fell while req was still high");
		end

	ack_low_after_reset: assert property (@(posedge clk)
		$fell(reset) |-> !ack)
		else begin
			assert_fails++;
			$error("ack high right after reset");
		end

	// Interrupt vector points at an enabled source
	irq_vec_enabled: assert property (@(posedge clk) disable iff (reset)
		irq |-> irq_en[irq_vec])
		else begin
			assert_fails++;
			$error("irq_vec selects a disabled source");
		end

endmodule

bind io_bus_slave gus_io_checker chk_i (
	.clk, .reset, .req, .ack, .irq, .irq_vec, .irq_en
);

// File: design/gus_io_top.sv
// Peripheral block top level. Single clock domain on clk.
// Host accesses use the four-phase req/ack rule; bus must be stable while req is high.
// rxd is asynchronous and is synchronized inside the receiver.
`timescale 1ns/1ps

module gus_io_top (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 req,
	input  gus_io_pkg::io_req_t  bus,
	output logic                 ack,
	output gus_io_pkg::io_word_t rdata,
	input  gus_io_pkg::gp_in_t   gp_in,
	input  logic                 rxd,
	output logic                 txd,
	output logic                 pwm_out,
	output logic                 gpo,
	output logic                 irq,
	output gus_io_pkg::irq_vec_t irq_vec
);

	logic                   tx_rdy;    // Transmitter idle
	logic                   rx_valid;  // Received byte pending
	logic                   overrun;   // Byte lost
	logic                   frame_err; // Bad stop bit
	gus_io_pkg::uart_byte_t rx_data;
	logic                   pwm_flag;  // Period interrupt flag
	logic                   tx_start;  // One-cycle strobes from the slave
	gus_io_pkg::uart_byte_t tx_data;
	logic                   rx_clear;
	logic                   duty_wr;
	gus_io_pkg::pwm_duty_t  duty;

	io_bus_slave u_slave (
		.clk, .reset, .req, .bus, .ack, .rdata, .gp_in,
		.tx_rdy, .rx_valid, .overrun, .frame_err, .rx_data, .pwm_flag,
		.tx_start, .tx_data, .rx_clear, .duty_wr, .duty,
		.gpo, .irq, .irq_vec
	);

	pwm_gen u_pwm (
		.clk, .reset, .duty_wr, .duty, .pwm_out, .pwm_flag
	);

	uart_tx u_uart_tx (
		.clk, .reset, .tx_start, .tx_data, .txd, .tx_rdy
	);

	uart_rx u_uart_rx (
		.clk, .reset, .rxd, .rx_clear, .rx_data, .rx_valid, .overrun, .frame_err
	);

endmodule

// File: design/uart_rx.sv
// 8N1 receiver with a one-byte buffer. rxd is asynchronous and goes through two flops.
// Every line edge re-aligns the divider; the line is sampled in the middle of each bit.
// A frame that completes while a byte is pending sets overrun and replaces the byte.
`timescale 1ns/1ps
`include "gus_io_macros.svh"

module uart_rx (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   rxd,
	input  logic                   rx_clear,
	output gus_io_pkg::uart_byte_t rx_data,
	output logic                   rx_valid,
	output logic                   overrun,
	output logic                   frame_err
);

	localparam int DIV_BITS = $clog2(`GUS_IO_UART_DIVIDER);
	localparam logic [DIV_BITS-1:0] DIV_LAST = DIV_BITS'(`GUS_IO_UART_DIVIDER - 1);
	localparam logic [DIV_BITS-1:0] DIV_MID  = DIV_BITS'(`GUS_IO_UART_DIVIDER / 2 - 1);

	logic [1:0]          rx_sync;    // Two-flop synchronizer
	logic                rx_edge;    // Transition on the line
	logic [DIV_BITS-1:0] rx_div;
	logic                rx_sample;  // Mid-bit strobe
	logic [9:0]          rx_sh;      // Frame shifts in at the MSB
	logic                frame_done; // Start bit reached the LSB
	logic [8:0]          rx_buf;     // Stop bit and data
	logic [1:0]          rx_hist;    // {overrun, valid}

	assign rx_edge    = rx_sync[1] ^ rx_sync[0];
	assign rx_sample  = (rx_div == DIV_MID);
	assign frame_done = ~rx_sh[0];

	// ---------------------------------------------------------------------------
	// Synchronizer and bit timing
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_sync <= 2'b11;  // Idle line
			rx_div  <= '0;
		end else begin
			rx_sync <= {rx_sync[0], rxd};
			if (rx_edge || rx_div == DIV_LAST)
				rx_div <= '0;  // Re-align on every edge
			else
				rx_div <= rx_div + 1'b1;
		end
	end

	// Frame assembly and buffer
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_sh  <= '1;
			rx_buf <= 9'h100;  // Good stop bit, no error shown
		end else if (frame_done) begin
			rx_sh  <= '1;  // Rearm for the next start bit
			rx_buf <= rx_sh[9:1];
		end else if (rx_sample) begin
			rx_sh <= {rx_sync[1], rx_sh[9:1]};
		end
	end

	// Valid and overrun history, completion wins over clear
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			rx_hist <= '0;
		else if (frame_done)
			rx_hist <= {rx_hist[0], 1'b1};
		else if (rx_clear)
			rx_hist <= '0;
	end

	assign rx_data   = rx_buf[7:0];
	assign frame_err = ~rx_buf[8];  // Stop bit read as 0
	assign rx_valid  = rx_hist[0];
	assign overrun   = rx_hist[1];

endmodule

// File: design/uart_tx.sv
// 8N1 transmitter, one stop bit only. tx_start must only come while tx_rdy is high;
// the bus slave holds off UART writes until then.
// txd idles high and each bit lasts GUS_IO_UART_DIVIDER cycles.
`timescale 1ns/1ps
`include "gus_io_macros.svh"

module uart_tx (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   tx_start,
	input  gus_io_pkg::uart_byte_t tx_data,
	output logic                   txd,
	output logic                   tx_rdy
);

	localparam int DIV_BITS = $clog2(`GUS_IO_UART_DIVIDER);
	localparam logic [DIV_BITS-1:0] DIV_LAST = DIV_BITS'(`GUS_IO_UART_DIVIDER - 1);

	logic [DIV_BITS-1:0] tx_div;    // Bit time divider
	logic                div_last;  // End of a bit time
	logic [8:0]          tx_sh;     // Data plus start bit, LSB on the line
	logic [3:0]          bit_cnt;   // Bits left, zero when idle
	logic                busy;

	assign div_last = (tx_div == DIV_LAST);
	assign busy     = |bit_cnt;
	assign tx_rdy   = ~busy;
	assign txd      = tx_sh[0];

	// ---------------------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tx_div  <= '0;
			tx_sh   <= '1;  // Line idle high
			bit_cnt <= '0;
		end else begin
			if (tx_start || div_last)
				tx_div <= '0;  // Restart aligns the first bit
			else
				tx_div <= tx_div + 1'b1;

			if (tx_start)
				tx_sh <= {tx_data, 1'b0};  // Start bit first
			else if (div_last)
				tx_sh <= {1'b1, tx_sh[8:1]};  // Ones shift in for stop

			if (tx_start)
				bit_cnt <= 4'd10;  // Start, 8 data, stop
			else if (busy && div_last)
				bit_cnt <= bit_cnt - 1'b1;
		end
	end

endmodule

// File: design/pwm_gen.sv
// Free-running PWM. The counter runs 0 to 2^N-2, so one period is 2^N-1 cycles.
// A new duty value takes effect at the next count zero. Duty 0 keeps the output
// low and the all-ones duty keeps it high.
`timescale 1ns/1ps
`include "gus_io_macros.svh"

module pwm_gen (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  duty_wr,
	input  gus_io_pkg::pwm_duty_t duty,
	output logic                  pwm_out,
	output logic                  pwm_flag
);

	localparam int N = `GUS_IO_PWM_BITS;
	localparam logic [N-1:0] CNT_LAST = {{(N-1){1'b1}}, 1'b0};  // 2^N-2

	gus_io_pkg::pwm_duty_t duty_hold;  // Written by the host
	gus_io_pkg::pwm_duty_t duty_buf;   // Copy used for this period
	logic [N-1:0]          cnt;
	logic                  cnt_zero;
	logic                  cnt_last;
	logic                  cnt_match;

	assign cnt_zero  = (cnt == '0);
	assign cnt_last  = (cnt == CNT_LAST);
	assign cnt_match = (cnt == duty_buf);

	// ---------------------------------------------------------------------------
	// Duty register and period buffer
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			duty_hold <= '0;
			duty_buf  <= '0;
		end else begin
			if (duty_wr)
				duty_hold <= duty;
			if (cnt_zero)
				duty_buf <= duty_hold;  // Reload once per period
		end
	end

	// Counter, output and period flag
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cnt      <= '0;
			pwm_out  <= 1'b0;
			pwm_flag <= 1'b0;
		end else begin
			cnt      <= cnt_last ? '0 : cnt + 1'b1;
			pwm_out  <= cnt_match ? 1'b0 : (cnt_zero ? 1'b1 : pwm_out);  // Match wins
			pwm_flag <= cnt_zero ? 1'b1 : (duty_wr ? 1'b0 : pwm_flag);
		end
	end

endmodule

// File: design/io_bus_slave.sv
// Register slave on a four-phase req/ack port, one access at a time.
// Every access spends at least one cycle in BUS_WAIT, so ack rises one cycle after
// req is sampled. UART data writes wait for tx_rdy and reads wait for rx_valid.
// Strobes to the peripherals are combinational and act at the edge where ack rises.
`timescale 1ns/1ps
`include "gus_io_macros.svh"

module io_bus_slave (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   req,
	input  gus_io_pkg::io_req_t    bus,
	output logic                   ack,
	output gus_io_pkg::io_word_t   rdata,
	input  gus_io_pkg::gp_in_t     gp_in,
	input  logic                   tx_rdy,
	input  logic                   rx_valid,
	input  logic                   overrun,
	input  logic                   frame_err,
	input  gus_io_pkg::uart_byte_t rx_data,
	input  logic                   pwm_flag,
	output logic                   tx_start,
	output gus_io_pkg::uart_byte_t tx_data,
	output logic                   rx_clear,
	output logic                   duty_wr,
	output gus_io_pkg::pwm_duty_t  duty,
	output logic                   gpo,
	output logic                   irq,
	output gus_io_pkg::irq_vec_t   irq_vec
);

	gus_io_pkg::bus_state_t state;
	gus_io_pkg::bus_state_t state_nxt;
	gus_io_pkg::irq_en_t    irq_en;    // Interrupt enable register
	gus_io_pkg::io_word_t   rd_word;   // Readback mux output
	gus_io_pkg::io_word_t   flag_word;
	logic                   uart_sel;  // Access targets UART data
	logic                   stall;     // UART not ready for this access
	logic                   go;        // Access completes at next edge
	logic                   wr_go;
	logic [3:0]             irq_src;   // Masked request sources

	// ---------------------------------------------------------------------------
	// Handshake FSM
	assign uart_sel = (bus.addr == `GUS_IO_ADDR_UART);
	assign stall    = uart_sel && (bus.we ? !tx_rdy : !rx_valid);
	assign go       = (state == gus_io_pkg::BUS_WAIT) && !stall;
	assign wr_go    = go && bus.we;
	assign ack      = (state == gus_io_pkg::BUS_ACK);

	always_comb begin
		state_nxt = state;
		case (state)
			gus_io_pkg::BUS_IDLE: if (req) state_nxt = gus_io_pkg::BUS_WAIT;
			gus_io_pkg::BUS_WAIT: if (!stall) state_nxt = gus_io_pkg::BUS_ACK;
			gus_io_pkg::BUS_ACK:  if (!req) state_nxt = gus_io_pkg::BUS_IDLE;
			default:              state_nxt = gus_io_pkg::BUS_IDLE;
		endcase
	end

	// Peripheral strobes
	assign tx_start = wr_go && uart_sel;
	assign tx_data  = bus.wdata[7:0];
	assign rx_clear = go && !bus.we && uart_sel;  // Read pops the RX byte
	assign duty_wr  = wr_go && (bus.addr == `GUS_IO_ADDR_PWM_FLAGS);
	assign duty     = bus.wdata[`GUS_IO_PWM_BITS-1:0];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state  <= gus_io_pkg::BUS_IDLE;
			irq_en <= '0;
			gpo    <= 1'b0;
		end else begin
			state <= state_nxt;
			if (wr_go && bus.addr == `GUS_IO_ADDR_IRQEN)
				irq_en <= bus.wdata[3:0];  // All 4 bits stored
			if (wr_go && bus.addr == `GUS_IO_ADDR_PORT)
				gpo <= bus.wdata[0];
		end
	end

	// ---------------------------------------------------------------------------
	// Readback
	always_comb begin
		flag_word = '0;
		flag_word[`GUS_IO_FLAG_RXVALID] = rx_valid;
		flag_word[`GUS_IO_FLAG_TXRDY]   = tx_rdy;
		flag_word[`GUS_IO_FLAG_OVERRUN] = overrun;
		flag_word[`GUS_IO_FLAG_FRAME]   = frame_err;
		flag_word[`GUS_IO_FLAG_PWM]     = pwm_flag;  // Timer flag stays zero
	end

	always_comb begin
		case (bus.addr)
			`GUS_IO_ADDR_IRQEN:     rd_word = {12'h000, irq_en};
			`GUS_IO_ADDR_PWM_FLAGS: rd_word = flag_word;
			`GUS_IO_ADDR_UART:      rd_word = {8'h00, rx_data};
			`GUS_IO_ADDR_PORT:      rd_word = {8'h00, gp_in, gpo};
			default:                rd_word = '0;  // Unused slots
		endcase
	end

	always_ff @(posedge clk) begin
		if (go)
			rdata <= rd_word;  // Held while ack is high
	end

	// ---------------------------------------------------------------------------
	// Fixed-priority interrupt, lowest index wins
	assign irq_src = {pwm_flag & irq_en[3], 1'b0, tx_rdy & irq_en[1], rx_valid & irq_en[0]};
	assign irq     = |irq_src;

	always_comb begin
		if (irq_src[0])
			irq_vec = 2'd0;
		else if (irq_src[1])
			irq_vec = 2'd1;
		else
			irq_vec = 2'd3;  // PWM, also the idle value
	end

endmodule

// File: design/gus_io_pkg.sv
// Shared types of the peripheral block.
// Widths that depend on configuration come from the macro header.
`include "gus_io_macros.svh"

package gus_io_pkg;

	// ---------------------------------------------------------------------------
	// Data widths
	typedef logic [15:0] io_word_t;   // Bus data word
	typedef logic [2:0]  io_addr_t;   // Register select
	typedef logic [7:0]  uart_byte_t; // One serial character

	typedef logic [`GUS_IO_PWM_BITS-1:0] pwm_duty_t; // PWM compare value

	// Interrupt enable, bit 2 is the timer slot and has no source
	typedef logic [3:0]  irq_en_t;
	typedef logic [1:0]  irq_vec_t;   // Index of the winning source
	typedef logic [6:0]  gp_in_t;     // Input port pins

	// ---------------------------------------------------------------------------
	// Host request, held stable while req is high
	typedef struct packed {
		io_addr_t addr;  // Register address
		logic     we;    // 1 for write
		io_word_t wdata; // Write data
	} io_req_t;

	// Handshake FSM
	typedef enum logic [1:0] {
		BUS_IDLE, // Waiting for req
		BUS_WAIT, // Access accepted, may stall on UART
		BUS_ACK   // ack high until req drops
	} bus_state_t;

endpackage

// File: design/gus_io_macros.svh
// Register map and fixed parameters of the peripheral block.
// The UART divider is given in clk cycles per bit and is kept small for simulation.
// Addresses 3 and 5 to 7 are unused and read as zero.
`ifndef GUS_IO_MACROS_SVH
`define GUS_IO_MACROS_SVH

// ---------------------------------------------------------------------------
// Register addresses
`define GUS_IO_ADDR_IRQEN     3'd0  // Interrupt enable mask
`define GUS_IO_ADDR_PWM_FLAGS 3'd1  // Write PWM duty, read flag word
`define GUS_IO_ADDR_UART      3'd2  // UART data, TX on write, RX on read
`define GUS_IO_ADDR_PORT      3'd4  // GPO on write, input port on read

// ---------------------------------------------------------------------------
// Peripheral sizing
`define GUS_IO_PWM_BITS       8     // PWM resolution, period 2^N-1
// Hardware would use clock rate divided by baud rate here
`define GUS_IO_UART_DIVIDER   16    // Cycles per serial bit

// Bit positions in the flag word
`define GUS_IO_FLAG_RXVALID   0
`define GUS_IO_FLAG_TXRDY     1
`define GUS_IO_FLAG_OVERRUN   2
`define GUS_IO_FLAG_FRAME     3
`define GUS_IO_FLAG_PWM       4

`endif
